//--- all.f
logic/motor_pkg.sv
logic/pwm_timer.sv
logic/motor_regs.sv
logic/motor_fsm.sv
logic/commutator.sv
logic/bridge_driver.sv
logic/motor_top.sv
testbench/motor_tb.sv

//--- logic/bridge_driver.sv
// Three-phase bridge driver
`timescale 1ns/1ns

module bridge_driver #(
	parameter int PHASE_W   = 9,
	parameter int DEAD_TIME = 10
) (
	input  logic                   clk,
	input  logic                   rst,
	input  motor_pkg::pwm_tick_t   tick,
	input  logic [PHASE_W-1:0]     level,
	input  motor_pkg::bridge_out_t drive,
	input  motor_pkg::drive_cmd_t  cmd,
	output logic [PHASE_W-1:0]     active_level,
	output motor_pkg::bridge_out_t motor_out
);

	// One extra bit so a threshold past the top of the period never matches
	localparam int TH_W = PHASE_W + 1;

	logic [PHASE_W-1:0]     phase;
	logic [TH_W-1:0]        inv_threshold;
	logic                   pwm_active;
	logic                   pwm_inverted;
	motor_pkg::bridge_out_t bridge_next;

	// One half-bridge for one PWM slot
	function automatic motor_pkg::bridge_code_t half_bridge(
		input motor_pkg::bridge_code_t code,
		input logic                    active,
		input logic                    inverted,
		input logic                    fast
	);
		motor_pkg::bridge_code_t clean;
		clean = (code == motor_pkg::NOFF) ? motor_pkg::OFF : code;
		if (active) begin
			return clean;
		end
		// Slow decay recirculates through the low side of driven phases
		if (!fast && inverted && clean != motor_pkg::OFF) begin
			return motor_pkg::LOW;
		end
		return motor_pkg::OFF;
	endfunction

	assign phase = tick.phase[PHASE_W-1:0];

	// Level changes only at the update point so a period is never cut short
	always_ff @(posedge clk) begin
		if (rst) begin
			active_level <= '0;
		end else if (tick.update) begin
			active_level <= level;
		end
	end

	// Dead time delays only the inverted side
	// Fast decay and braking use the active side alone and are unaffected
	assign inv_threshold = {1'b0, active_level} + TH_W'(DEAD_TIME);
	assign pwm_active    = (phase < active_level);
	assign pwm_inverted  = ({1'b0, phase} >= inv_threshold);

	always_comb begin
		case (cmd.state)
			motor_pkg::RUN: begin
				bridge_next.u = half_bridge(drive.u, pwm_active, pwm_inverted, cmd.fast_decay);
				bridge_next.v = half_bridge(drive.v, pwm_active, pwm_inverted, cmd.fast_decay);
				bridge_next.w = half_bridge(drive.w, pwm_active, pwm_inverted, cmd.fast_decay);
			end
			motor_pkg::BRAKE: begin
				// All low sides on shorts the windings
				bridge_next = '{u: motor_pkg::LOW, v: motor_pkg::LOW, w: motor_pkg::LOW};
			end
			default: begin
				bridge_next = '{u: motor_pkg::OFF, v: motor_pkg::OFF, w: motor_pkg::OFF};
			end
		endcase
	end

	// Registered so the gate drivers never see decode glitches
	always_ff @(posedge clk) begin
		if (rst) begin
			motor_out <= '{u: motor_pkg::OFF, v: motor_pkg::OFF, w: motor_pkg::OFF};
		end else begin
			motor_out <= bridge_next;
		end
	end

	// Reverse direction creates NOFF upstream and it must be gone by here
	a_no_noff: assert property (
		@(posedge clk) disable iff (rst)
		motor_out.u != motor_pkg::NOFF &&
		motor_out.v != motor_pkg::NOFF &&
		motor_out.w != motor_pkg::NOFF
	);

endmodule

//--- logic/commutator.sv
// Hall sensor commutator
`timescale 1ns/1ns

module commutator (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [2:0]             hall,
	input  logic                   update,
	input  logic                   direction,
	output motor_pkg::bridge_out_t drive,
	output logic [2:0]             hall_sync,
	output logic                   hall_invalid
);

	logic [2:0]             hall_meta;
	logic                   dir_active;
	motor_pkg::bridge_out_t com;

	// Two flops for the asynchronous hall lines
	always_ff @(posedge clk) begin
		hall_meta <= hall;
		hall_sync <= hall_meta;
	end

	// Direction only changes at the PWM update point
	always_ff @(posedge clk) begin
		if (rst) begin
			dir_active <= 1'b0;
		end else if (update) begin
			dir_active <= direction;
		end
	end

	// Six-step table for the forward direction, phases in u, v, w order
	always_comb begin
		case (hall_sync)
			3'b101:  com = '{u: motor_pkg::HIGH, v: motor_pkg::LOW,  w: motor_pkg::OFF};
			3'b100:  com = '{u: motor_pkg::HIGH, v: motor_pkg::OFF,  w: motor_pkg::LOW};
			3'b110:  com = '{u: motor_pkg::OFF,  v: motor_pkg::HIGH, w: motor_pkg::LOW};
			3'b010:  com = '{u: motor_pkg::LOW,  v: motor_pkg::HIGH, w: motor_pkg::OFF};
			3'b011:  com = '{u: motor_pkg::LOW,  v: motor_pkg::OFF,  w: motor_pkg::HIGH};
			3'b001:  com = '{u: motor_pkg::OFF,  v: motor_pkg::LOW,  w: motor_pkg::HIGH};
			default: com = '{u: motor_pkg::OFF,  v: motor_pkg::OFF,  w: motor_pkg::OFF};
		endcase
	end

	// Reverse swaps HIGH and LOW on every phase
	// OFF becomes NOFF here and the bridge driver treats it as OFF
	assign drive = dir_active ? motor_pkg::bridge_out_t'(~com) : com;

	// All three sensors equal cannot happen on a healthy motor
	// One or two stuck sensors can still look valid and are left to the CPU
	assign hall_invalid = (hall_sync == 3'b000) || (hall_sync == 3'b111);

endmodule

//--- logic/motor_fsm.sv
// Motor control state machine
`timescale 1ns/1ns

module motor_fsm (
	input  logic                  clk,
	input  logic                  rst,
	input  motor_pkg::ctrl_t      ctrl,
	input  logic                  hall_invalid,
	output motor_pkg::drive_cmd_t cmd,
	output logic                  fault
);

	motor_pkg::motor_state_t state;
	motor_pkg::motor_state_t next_state;
	logic                    fault_cause;

	// A bad hall pattern only matters while the motor is enabled
	assign fault_cause = ctrl.enable && hall_invalid;

	always_comb begin
		next_state = state;
		case (state)
			motor_pkg::IDLE: begin
				if (fault_cause) begin
					next_state = motor_pkg::FAULT;
				end else if (ctrl.brake) begin
					next_state = motor_pkg::BRAKE;
				end else if (ctrl.enable) begin
					next_state = motor_pkg::RUN;
				end
			end
			motor_pkg::RUN: begin
				if (fault_cause) begin
					next_state = motor_pkg::FAULT;
				end else if (ctrl.brake) begin
					next_state = motor_pkg::BRAKE;
				end else if (!ctrl.enable) begin
					next_state = motor_pkg::IDLE;
				end
			end
			motor_pkg::BRAKE: begin
				if (fault_cause) begin
					next_state = motor_pkg::FAULT;
				end else if (!ctrl.brake) begin
					next_state = ctrl.enable ? motor_pkg::RUN : motor_pkg::IDLE;
				end
			end
			default: begin
				// Faults stay latched until software clears them with good hall
				// inputs, so a glitch cannot restart the motor on its own
				if (ctrl.clear_fault && !hall_invalid) begin
					next_state = motor_pkg::IDLE;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state          <= motor_pkg::IDLE;
			cmd.fast_decay <= 1'b0;
		end else begin
			state <= next_state;
			// Registered alongside the state so both change on the same edge
			cmd.fast_decay <= ctrl.fast_decay;
		end
	end

	assign cmd.state = state;
	assign fault     = (state == motor_pkg::FAULT);

	// Leaving FAULT takes a clear_fault write in the cycle before
	a_fault_latched: assert property (
		@(posedge clk) disable iff (rst)
		(state == motor_pkg::FAULT && !ctrl.clear_fault) |=> state == motor_pkg::FAULT
	);

endmodule

//--- logic/motor_pkg.sv
// Motor control shared types
package motor_pkg;

	// Upper bound on the PWM phase width carried by the tick bus
	// Modules fill or use only the low PHASE_W bits
	localparam int PHASE_MAX_W = 16;

	// Drive code for one half-bridge
	// NOFF is the bitwise inverse of OFF and means the same thing
	typedef enum logic [1:0] {
		OFF  = 2'b00,
		LOW  = 2'b01,
		HIGH = 2'b10,
		NOFF = 2'b11
	} bridge_code_t;

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		RUN   = 2'd1,
		BRAKE = 2'd2,
		FAULT = 2'd3
	} motor_state_t;

	// Wishbone word index, taken from adr[3:2]
	// Word 3 is unmapped
	typedef enum logic [1:0] {
		CTRL   = 2'd0,
		LEVEL  = 2'd1,
		STATUS = 2'd2
	} reg_addr_t;

	// CTRL register, bit 4 is enable down to bit 0 which is clear_fault
	typedef struct packed {
		logic enable;
		logic direction;
		logic brake;
		logic fast_decay;
		logic clear_fault;
	} ctrl_t;

	typedef struct packed {
		logic [PHASE_MAX_W-1:0] phase;
		logic                   update;
	} pwm_tick_t;

	typedef struct packed {
		motor_state_t state;
		logic         fast_decay;
	} drive_cmd_t;

	typedef struct packed {
		bridge_code_t u;
		bridge_code_t v;
		bridge_code_t w;
	} bridge_out_t;

endpackage

//--- logic/motor_regs.sv
// Motor control registers
`timescale 1ns/1ns

module motor_regs #(
	parameter int PHASE_W = 9
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    cyc,
	input  logic                    stb,
	input  logic                    we,
	input  logic [3:0]              adr,
	input  logic [31:0]             dat_w,
	output logic [31:0]             dat_r,
	output logic                    ack,
	input  motor_pkg::motor_state_t state,
	input  logic [2:0]              hall_sync,
	input  logic [PHASE_W-1:0]      active_level,
	output motor_pkg::ctrl_t        ctrl,
	output logic [PHASE_W-1:0]      level
);

	localparam int CTRL_W = $bits(motor_pkg::ctrl_t);

	logic                 req;
	motor_pkg::reg_addr_t word;
	motor_pkg::ctrl_t     ctrl_rd;
	logic [31:0]          status_word;
	logic [31:0]          rd_word;

	// A new request is one where ack has not yet been given
	// Holding stb high therefore yields an ack every other cycle
	assign req  = cyc && stb && !ack;
	assign word = motor_pkg::reg_addr_t'(adr[3:2]);

	always_ff @(posedge clk) begin
		if (rst) begin
			ack   <= 1'b0;
			ctrl  <= '0;
			level <= '0;
		end else begin
			ack <= req;
			// clear_fault lives for the ack cycle only
			ctrl.clear_fault <= 1'b0;
			if (req && we) begin
				case (word)
					motor_pkg::CTRL:  ctrl  <= motor_pkg::ctrl_t'(dat_w[CTRL_W-1:0]);
					motor_pkg::LEVEL: level <= dat_w[PHASE_W-1:0];
					// STATUS and the unmapped word take no writes
					default: ;
				endcase
			end
		end
	end

	// The pulse bit never shows up in a CTRL read
	always_comb begin
		ctrl_rd = ctrl;
		ctrl_rd.clear_fault = 1'b0;
	end

	// STATUS holds the state, the synchronized hall value and the level in use
	// The level field starts at bit 8 and is PHASE_W bits wide
	always_comb begin
		status_word = '0;
		status_word[1:0] = state;
		status_word[4:2] = hall_sync;
		status_word[8 +: PHASE_W] = active_level;
	end

	always_comb begin
		rd_word = '0;
		case (word)
			motor_pkg::CTRL:   rd_word[CTRL_W-1:0] = ctrl_rd;
			motor_pkg::LEVEL:  rd_word[PHASE_W-1:0] = level;
			motor_pkg::STATUS: rd_word = status_word;
			default:           rd_word = '0;
		endcase
	end

	// Read data is loaded on the same edge that raises ack
	always_ff @(posedge clk) begin
		if (req) begin
			dat_r <= rd_word;
		end
	end

	// An ack belongs to a cycle the master is still holding open
	a_ack_in_cycle: assert property (
		@(posedge clk) disable iff (rst)
		ack |-> (cyc && stb)
	);

endmodule

//--- logic/motor_top.sv
// Brushless motor controller
`timescale 1ns/1ns

module motor_top #(
	parameter int PHASE_W   = 9,
	parameter int DEAD_TIME = 10
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cyc,
	input  logic                   stb,
	input  logic                   we,
	input  logic [3:0]             adr,
	input  logic [31:0]            dat_w,
	output logic [31:0]            dat_r,
	output logic                   ack,
	input  logic [2:0]             hall,
	output motor_pkg::bridge_out_t motor_out,
	output logic                   fault
);

	motor_pkg::pwm_tick_t   tick;
	motor_pkg::ctrl_t       ctrl;
	motor_pkg::drive_cmd_t  cmd;
	motor_pkg::bridge_out_t drive;
	logic [PHASE_W-1:0]     level;
	logic [PHASE_W-1:0]     active_level;
	logic [2:0]             hall_sync;
	logic                   hall_invalid;

	pwm_timer #(.PHASE_W(PHASE_W)) u_timer (
		.clk  (clk),
		.rst  (rst),
		.tick (tick)
	);

	// Host side, STATUS reports the state the bridge is acting on
	motor_regs #(.PHASE_W(PHASE_W)) u_regs (
		.clk          (clk),
		.rst          (rst),
		.cyc          (cyc),
		.stb          (stb),
		.we           (we),
		.adr          (adr),
		.dat_w        (dat_w),
		.dat_r        (dat_r),
		.ack          (ack),
		.state        (cmd.state),
		.hall_sync    (hall_sync),
		.active_level (active_level),
		.ctrl         (ctrl),
		.level        (level)
	);

	motor_fsm u_fsm (
		.clk          (clk),
		.rst          (rst),
		.ctrl         (ctrl),
		.hall_invalid (hall_invalid),
		.cmd          (cmd),
		.fault        (fault)
	);

	commutator u_commutator (
		.clk          (clk),
		.rst          (rst),
		.hall         (hall),
		.update       (tick.update),
		.direction    (ctrl.direction),
		.drive        (drive),
		.hall_sync    (hall_sync),
		.hall_invalid (hall_invalid)
	);

	bridge_driver #(.PHASE_W(PHASE_W), .DEAD_TIME(DEAD_TIME)) u_bridge (
		.clk          (clk),
		.rst          (rst),
		.tick         (tick),
		.level        (level),
		.drive        (drive),
		.cmd          (cmd),
		.active_level (active_level),
		.motor_out    (motor_out)
	);

endmodule

//--- logic/pwm_timer.sv
// PWM phase timer
`timescale 1ns/1ns

module pwm_timer #(
	parameter int PHASE_W = 9
) (
	input  logic                 clk,
	input  logic                 rst,
	output motor_pkg::pwm_tick_t tick
);

	// The update point sits one count before the wrap
	localparam logic [PHASE_W-1:0] UPDATE_PHASE = {{(PHASE_W-1){1'b1}}, 1'b0};

	logic [PHASE_W-1:0] phase;

	// The tick bus has a fixed maximum phase width
	if (PHASE_W > motor_pkg::PHASE_MAX_W) begin : g_width_check
		$error("PHASE_W is wider than the tick bus");
	end

	// Free-running counter with no prescaler
	// Reset leaves it at zero so the first cycle after reset has phase 0
	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	always_comb begin
		tick = '0;
		tick.phase[PHASE_W-1:0] = phase;
		// New level and direction values are taken on this cycle
		tick.update = (phase == UPDATE_PHASE);
	end

	// One strobe per PWM period
	// Two in a row would mean the period collapsed to a single count
	a_update_single: assert property (
		@(posedge clk) disable iff (rst)
		tick.update |=> !tick.update
	);

endmodule

//--- run.sh
#!/bin/bash
# Build and run the motor controller simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module motor_tb \
	-f all.f \
	--Mdir obj_dir -o motor_sim

# The simulator may stop with an error, the log decides the result
./obj_dir/motor_sim | tee sim.log

if grep -q "All tests passed" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

//--- testbench/motor_tb.sv
// Motor controller testbench
`timescale 1ns/1ns

module motor_tb;

	localparam int PHASE_W = 9;
	localparam int DEAD_TIME = 10;
	localparam int PERIOD = 2 ** PHASE_W;
	localparam int WAIT_LIMIT = 8;
	localparam logic [3:0] ADR_CTRL = 4'h0;
	localparam logic [3:0] ADR_LEVEL = 4'h4;
	localparam logic [3:0] ADR_STATUS = 4'h8;
	localparam logic [3:0] ADR_UNMAPPED = 4'hc;

	logic clk = 1'b0;
	logic rst;
	logic cyc;
	logic stb;
	logic we;
	logic [3:0] adr;
	logic [31:0] dat_w;
	logic [31:0] dat_r;
	logic ack;
	logic [2:0] hall;
	motor_pkg::bridge_out_t motor_out;
	logic fault;

	integer seed = 32'hee01_db13;

	// Reference model state advances on every rising edge
	logic model_live = 1'b0;
	int m_phase;
	int m_level;
	int m_lvl_act;
	logic m_dir_act;
	logic m_fast;
	logic m_ack;
	logic [2:0] m_h1;
	logic [2:0] m_h2;
	logic [31:0] m_rdata;
	motor_pkg::ctrl_t m_ctrl;
	motor_pkg::motor_state_t m_state;
	motor_pkg::motor_state_t state_next;
	motor_pkg::bridge_out_t m_drive;
	motor_pkg::bridge_out_t m_out;
	motor_pkg::bridge_out_t out_next;
	logic req_now;

	logic [31:0] rd;
	int lvl;
	int lvl_old;
	logic dir;

	motor_top dut (
		.clk       (clk),
		.rst       (rst),
		.cyc       (cyc),
		.stb       (stb),
		.we        (we),
		.adr       (adr),
		.dat_w     (dat_w),
		.dat_r     (dat_r),
		.ack       (ack),
		.hall      (hall),
		.motor_out (motor_out),
		.fault     (fault)
	);

	always #10 clk = ~clk;

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic value_error(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		stop_run($sformatf("Fail %s: expected %0h, actual %0h", name, exp, act));
	endtask

	function automatic int pick(input int lo, input int hi);
		logic [31:0] r;
		r = $random(seed);
		return lo + int'(r % (hi - lo + 1));
	endfunction

	function automatic logic [31:0] ctrl_word(input logic en, input logic dr, input logic brk,
			input logic fast, input logic clr);
		return {27'b0, en, dr, brk, fast, clr};
	endfunction

	function automatic logic bad_hall(input logic [2:0] h);
		return h == 3'b000 || h == 3'b111;
	endfunction

	// Six-step table in u, v, w order
	// Reverse inverts every code
	function automatic motor_pkg::bridge_out_t commutate(input logic [2:0] h,
			input logic dr);
		motor_pkg::bridge_out_t d;
		case (h)
			3'b101: d = {motor_pkg::HIGH, motor_pkg::LOW, motor_pkg::OFF};
			3'b100: d = {motor_pkg::HIGH, motor_pkg::OFF, motor_pkg::LOW};
			3'b110: d = {motor_pkg::OFF, motor_pkg::HIGH, motor_pkg::LOW};
			3'b010: d = {motor_pkg::LOW, motor_pkg::HIGH, motor_pkg::OFF};
			3'b011: d = {motor_pkg::LOW, motor_pkg::OFF, motor_pkg::HIGH};
			3'b001: d = {motor_pkg::OFF, motor_pkg::LOW, motor_pkg::HIGH};
			default: d = '0;
		endcase
		if (dr) d = motor_pkg::bridge_out_t'(~d);
		return d;
	endfunction

	// The dead time only delays the recirculating low side of one half-bridge
	function automatic motor_pkg::bridge_code_t half_bridge_code(
			input motor_pkg::bridge_code_t code, input motor_pkg::motor_state_t st,
			input logic fast, input int ph, input int lv);
		motor_pkg::bridge_code_t c;
		c = (code == motor_pkg::NOFF) ? motor_pkg::OFF : code;
		if (st == motor_pkg::BRAKE) return motor_pkg::LOW;
		if (st != motor_pkg::RUN) return motor_pkg::OFF;
		if (ph < lv) return c;
		if (!fast && ph >= lv + DEAD_TIME && c != motor_pkg::OFF) return motor_pkg::LOW;
		return motor_pkg::OFF;
	endfunction

	function automatic motor_pkg::motor_state_t state_step(input motor_pkg::motor_state_t st,
			input motor_pkg::ctrl_t c, input logic bad);
		if (st == motor_pkg::FAULT) return (c.clear_fault && !bad) ? motor_pkg::IDLE : st;
		if (c.enable && bad) return motor_pkg::FAULT;
		if (c.brake) return motor_pkg::BRAKE;
		return c.enable ? motor_pkg::RUN : motor_pkg::IDLE;
	endfunction

	function automatic logic [31:0] register_read(input logic [1:0] word);
		logic [31:0] r;
		r = '0;
		case (word)
			2'd0: r[4:0] = {m_ctrl.enable, m_ctrl.direction, m_ctrl.brake,
					m_ctrl.fast_decay, 1'b0};
			2'd1: r[PHASE_W-1:0] = m_level[PHASE_W-1:0];
			2'd2: begin
				r[1:0] = m_state;
				r[4:2] = m_h2;
				r[8 +: PHASE_W] = m_lvl_act[PHASE_W-1:0];
			end
			default: r = '0;
		endcase
		return r;
	endfunction

	// Every value is computed from the pre-edge state before anything is updated
	always @(posedge clk) begin
		model_live = 1'b1;
		if (rst) begin
			m_phase = 0;
			m_level = 0;
			m_lvl_act = 0;
			m_dir_act = 1'b0;
			m_fast = 1'b0;
			m_ack = 1'b0;
			m_ctrl = '0;
			m_state = motor_pkg::IDLE;
			m_out = '0;
		end else begin
			req_now = cyc && stb && !m_ack;
			if (req_now) m_rdata = register_read(adr[3:2]);
			m_drive = commutate(m_h2, m_dir_act);
			out_next.u = half_bridge_code(m_drive.u, m_state, m_fast, m_phase, m_lvl_act);
			out_next.v = half_bridge_code(m_drive.v, m_state, m_fast, m_phase, m_lvl_act);
			out_next.w = half_bridge_code(m_drive.w, m_state, m_fast, m_phase, m_lvl_act);
			state_next = state_step(m_state, m_ctrl, bad_hall(m_h2));
			m_fast = m_ctrl.fast_decay;
			// Update point, one count before the wrap
			if (m_phase == PERIOD - 2) begin
				m_lvl_act = m_level;
				m_dir_act = m_ctrl.direction;
			end
			m_ack = req_now;
			m_ctrl.clear_fault = 1'b0;
			if (req_now && we && adr[3:2] == 2'd0) m_ctrl = dat_w[4:0];
			if (req_now && we && adr[3:2] == 2'd1) m_level = int'(dat_w[PHASE_W-1:0]);
			m_state = state_next;
			m_out = out_next;
			m_phase = (m_phase + 1) % PERIOD;
		end
		// The hall synchronizer has no reset
		m_h2 = m_h1;
		m_h1 = hall;
	end

	// Outputs are compared in the middle of the cycle where they are stable
	always @(negedge clk) begin
		if (model_live) begin
			assert (motor_out === m_out) else value_error("motor_out", m_out, motor_out);
			assert (ack === m_ack) else value_error("ack", m_ack, ack);
			assert (fault === (m_state == motor_pkg::FAULT))
				else value_error("fault", m_state == motor_pkg::FAULT, fault);
		end
	end

	task automatic wishbone_access(input logic wr, input logic [3:0] a, input logic [31:0] d,
			output logic [31:0] q);
		int n;
		repeat (pick(0, 3)) @(negedge clk);
		cyc = 1'b1;
		stb = 1'b1;
		we = wr;
		adr = a;
		dat_w = d;
		n = 0;
		@(negedge clk);
		while (!ack && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		assert (ack) else stop_run("Wishbone access was never acknowledged");
		q = dat_r;
		// The master holds the cycle open across the edge that samples ack
		@(negedge clk);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic write_reg(input logic [3:0] a, input logic [31:0] d);
		logic [31:0] ignored;
		wishbone_access(1'b1, a, d, ignored);
	endtask

	task automatic read_reg(input logic [3:0] a, output logic [31:0] d);
		wishbone_access(1'b0, a, 32'h0, d);
		assert (d === m_rdata) else value_error("read data", m_rdata, d);
	endtask

	task automatic wait_phase(input int target);
		int n;
		n = 0;
		while (m_phase != target && n <= PERIOD) begin
			@(negedge clk);
			n++;
		end
		assert (m_phase == target) else stop_run("PWM phase never reached the expected point");
	endtask

	// All six valid patterns in shuffled order
	task automatic sweep_hall();
		logic [2:0] pat [6];
		logic [2:0] t;
		int j;
		pat = '{3'b101, 3'b100, 3'b110, 3'b010, 3'b011, 3'b001};
		for (int k = 5; k > 0; k--) begin
			j = pick(0, k);
			t = pat[k];
			pat[k] = pat[j];
			pat[j] = t;
		end
		for (int k = 0; k < 6; k++) begin
			hall = pat[k];
			repeat (pick(4, 160)) @(negedge clk);
		end
	endtask

	initial begin
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = 4'h0;
		dat_w = 32'h0;
		hall = 3'b101;
		repeat (2) @(negedge clk);
		rst = 1'b0;

		// Reset values
		@(negedge clk);
		assert (motor_out == '0) else value_error("reset motor_out", 0, motor_out);
		assert (!fault) else value_error("reset fault", 0, fault);
		read_reg(ADR_STATUS, rd);
		assert (rd == 32'h14) else value_error("reset status", 32'h14, rd);

		// Slow decay run
		dir = pick(0, 1);
		write_reg(ADR_LEVEL, pick(30, 480));
		write_reg(ADR_CTRL, ctrl_word(1'b1, dir, 1'b0, 1'b0, 1'b0));
		sweep_hall();
		sweep_hall();

		// A level near the top pushes the dead-time threshold past the period
		write_reg(ADR_LEVEL, pick(PERIOD - DEAD_TIME, PERIOD - 1));
		sweep_hall();
		sweep_hall();

		// Fast decay over the whole level range including levels near the top
		for (int k = 0; k < 3; k++) begin
			write_reg(ADR_LEVEL, pick(0, PERIOD - 1));
			write_reg(ADR_CTRL, ctrl_word(1'b1, dir, 1'b0, 1'b1, 1'b0));
			sweep_hall();
		end

		// Brake shorts the windings and run resumes afterwards
		write_reg(ADR_CTRL, ctrl_word(1'b1, dir, 1'b1, 1'b0, 1'b0));
		repeat (3) @(negedge clk);
		assert (motor_out == 6'b010101)
			else value_error("brake motor_out", 6'b010101, motor_out);
		write_reg(ADR_CTRL, ctrl_word(1'b1, dir, 1'b0, 1'b0, 1'b0));
		read_reg(ADR_STATUS, rd);
		assert (rd[1:0] == motor_pkg::RUN)
			else value_error("resume state", motor_pkg::RUN, rd[1:0]);

		// Mid-period changes wait for the update point
		wait_phase(8);
		lvl_old = m_lvl_act;
		lvl = (lvl_old + pick(1, PERIOD - 1)) % PERIOD;
		write_reg(ADR_LEVEL, lvl);
		write_reg(ADR_CTRL, ctrl_word(1'b1, !dir, 1'b0, 1'b0, 1'b0));
		read_reg(ADR_STATUS, rd);
		assert (rd[8 +: PHASE_W] == lvl_old)
			else value_error("level before update", lvl_old, rd[8 +: PHASE_W]);
		wait_phase(PERIOD - 1);
		read_reg(ADR_STATUS, rd);
		assert (rd[8 +: PHASE_W] == lvl)
			else value_error("level after update", lvl, rd[8 +: PHASE_W]);
		sweep_hall();

		// A bad hall pattern latches the fault until it is cleared
		hall = pick(0, 1) ? 3'b111 : 3'b000;
		repeat (5) @(negedge clk);
		assert (fault) else value_error("fault raised", 1, fault);
		assert (motor_out == '0) else value_error("fault motor_out", 0, motor_out);
		hall = 3'b011;
		repeat (6) @(negedge clk);
		assert (fault && motor_out == '0) else stop_run("Fault did not stay latched with valid hall");
		write_reg(ADR_CTRL, ctrl_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
		repeat (2) @(negedge clk);
		assert (!fault) else value_error("fault cleared", 0, fault);
		read_reg(ADR_STATUS, rd);
		assert (rd[1:0] == motor_pkg::IDLE)
			else value_error("cleared state", motor_pkg::IDLE, rd[1:0]);

		// Mixed bus traffic with random gaps
		for (int k = 0; k < 24; k++) begin
			case (pick(0, 4))
				0: begin
					read_reg(ADR_UNMAPPED, rd);
					assert (rd == 32'h0) else value_error("unmapped read", 0, rd);
				end
				1: write_reg(ADR_LEVEL, $random(seed));
				2: write_reg(ADR_UNMAPPED, $random(seed));
				3: write_reg(ADR_STATUS, $random(seed));
				default: read_reg(pick(0, 2) * 4, rd);
			endcase
		end
		repeat (4) @(negedge clk);

		$display("All tests passed");
		$finish;
	end

endmodule
